// File: source/detectorPkg.sv
`default_nettype none

package detectorPkg;

    // --------------------
    // datapath widths
    // --------------------
    localparam int sampleWidth = 18;  // signed re/im parts and table entries
    localparam int metricWidth = 18;  // unsigned path metrics
    localparam logic [metricWidth-1:0] metricMax = '1;

    localparam int numPoints = 16;
    typedef logic [3:0] pointIndex;

    // products in pointSetup are scaled down by this
    localparam int setupShift = 2;

    // maps 2 index bits to a 16-QAM level
    function automatic logic signed [2:0] qamLevel(input logic [1:0] bits);
        case (bits)
            2'b00:   qamLevel = -3'sd3;
            2'b01:   qamLevel = -3'sd1;
            2'b10:   qamLevel = 3'sd1;
            default: qamLevel = 3'sd3;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/detectorControl.sv
`timescale 1ns/1ps
`default_nettype none

module detectorControl (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  logic frameStart,
    input  logic blockValid,
    input  logic stageSetupComplete,
    input  logic startNextStage,
    output logic startFrame,
    output logic startBlock,
    output logic startStage,
    output logic frameReady,
    output logic stageActive
);

    localparam logic [1:0] stIdle  = 2'd0;
    localparam logic [1:0] stSetup = 2'd1;
    localparam logic [1:0] stReady = 2'd2;
    localparam logic [1:0] stStage = 2'd3;

    logic [1:0] state;
    logic       blockGo;

    // frame start only counts while enabled
    assign startFrame = frameStart & clkEn;

    // --------------------
    // sequencing FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= stIdle;
            blockGo <= 1'b0;
        end else begin
            blockGo <= 1'b0;
            if (startFrame) begin
                state <= stSetup;  // restart from anywhere
            end else begin
                case (state)
                    stSetup: begin
                        if (stageSetupComplete)
                            state <= stReady;
                    end
                    stReady: begin
                        if (blockValid) begin
                            state   <= stStage;
                            blockGo <= 1'b1;
                        end
                    end
                    stStage: begin
                        if (startNextStage)
                            state <= stReady;
                    end
                    default: state <= stIdle;  // wait for a frame
                endcase
            end
        end
    end

    // block and stage start as one pulse pair
    assign startBlock  = blockGo;
    assign startStage  = blockGo;

    assign frameReady  = (state == stReady);
    assign stageActive = (state == stStage);

endmodule

`default_nettype wire

// File: source/pointSetup.sv
`timescale 1ns/1ps
`default_nettype none

module pointSetup import detectorPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          startFrame,
    input  logic signed [sampleWidth-1:0] chanReal,
    input  logic signed [sampleWidth-1:0] chanImag,
    output logic                          setupOutputValid,
    output logic                          stageSetupComplete,
    output logic signed [sampleWidth-1:0] setupReal,
    output logic signed [sampleWidth-1:0] setupImag
);

    localparam int prodWidth = sampleWidth + 4;  // 3-bit level times gain, plus sum

    logic signed [sampleWidth-1:0] gainReal;
    logic signed [sampleWidth-1:0] gainImag;
    pointIndex                     pointCnt;
    logic                          running;
    logic                          lastPoint;
    logic signed [2:0]             levelI;
    logic signed [2:0]             levelQ;
    logic signed [prodWidth-1:0]   prodReal;
    logic signed [prodWidth-1:0]   prodImag;

    always_ff @(posedge clk) begin
        if (startFrame) begin
            gainReal <= chanReal;
            gainImag <= chanImag;
        end
    end

    // --------------------
    // point walk
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            pointCnt <= '0;
        end else if (startFrame) begin
            running  <= 1'b1;
            pointCnt <= '0;
        end else if (running) begin
            pointCnt <= pointCnt + 4'd1;
            if (pointCnt == pointIndex'(numPoints - 1))
                running <= 1'b0;
        end
    end

    assign levelI = qamLevel(pointCnt[3:2]);
    assign levelQ = qamLevel(pointCnt[1:0]);

    // complex level times gain, then scaled
    assign prodReal = (levelI * gainReal - levelQ * gainImag) >>> setupShift;
    assign prodImag = (levelI * gainImag + levelQ * gainReal) >>> setupShift;

    // a restart drops anything still in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            setupOutputValid   <= 1'b0;
            lastPoint          <= 1'b0;
            stageSetupComplete <= 1'b0;
        end else begin
            setupOutputValid   <= running & ~startFrame;
            lastPoint          <= running & ~startFrame
                                  & (pointCnt == pointIndex'(numPoints - 1));
            stageSetupComplete <= lastPoint & ~startFrame;
        end
    end

    always_ff @(posedge clk) begin
        setupReal <= prodReal[sampleWidth-1:0];  // truncate
        setupImag <= prodImag[sampleWidth-1:0];
    end

endmodule

`default_nettype wire

// File: source/acsOp.sv
`timescale 1ns/1ps
`default_nettype none

module acsOp import detectorPkg::*; #(
    parameter int metricShift = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic signed [sampleWidth-1:0] yReal,
    input  logic signed [sampleWidth-1:0] yImag,
    input  logic signed [sampleWidth-1:0] sReal,
    input  logic signed [sampleWidth-1:0] sImag,
    input  logic                          accMetricInEn,
    input  logic        [metricWidth-1:0] accMetricIn,
    output logic                          accMetricOutEn,
    output logic        [metricWidth-1:0] accMetricOut
);

    localparam int sqWidth  = 2 * sampleWidth + 2;
    localparam int sumWidth = sqWidth + 1;

    logic signed [sampleWidth:0]   diffReal;
    logic signed [sampleWidth:0]   diffImag;
    logic        [sqWidth-1:0]     sqReal;
    logic        [sqWidth-1:0]     sqImag;
    logic        [metricWidth-1:0] metricDly;
    logic                          enDly;
    logic        [sumWidth-1:0]    distSum;
    logic        [sumWidth-1:0]    distScaled;
    logic        [sumWidth:0]      total;

    assign diffReal = yReal - sReal;
    assign diffImag = yImag - sImag;

    // --------------------
    // stage 1
    // --------------------
    always_ff @(posedge clk) begin
        sqReal    <= diffReal * diffReal;
        sqImag    <= diffImag * diffImag;
        metricDly <= accMetricIn;
    end

    // --------------------
    // stage 2
    // --------------------
    assign distSum    = sqReal + sqImag;
    assign distScaled = distSum >> metricShift;
    assign total      = distScaled + metricDly;

    always_ff @(posedge clk) begin
        accMetricOut <= (total > metricMax) ? metricMax : total[metricWidth-1:0];  // saturate
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enDly          <= 1'b0;
            accMetricOutEn <= 1'b0;
        end else begin
            enDly          <= accMetricInEn;
            accMetricOutEn <= enDly;
        end
    end

endmodule

`default_nettype wire

// File: source/acsStage.sv
`timescale 1ns/1ps
`default_nettype none

module acsStage import detectorPkg::*; #(
    parameter int metricShift = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clkEn,
    input  logic                          startFrame,
    input  logic                          startBlock,
    input  logic                          startStage,
    input  logic signed [sampleWidth-1:0] sampleReal,
    input  logic signed [sampleWidth-1:0] sampleImag,
    input  logic                          accMetricInEn,
    input  logic        [metricWidth-1:0] accMetricIn,
    input  logic                          setupOutputValid,
    input  logic signed [sampleWidth-1:0] setupReal,
    input  logic signed [sampleWidth-1:0] setupImag,
    output logic                          metricOutEn,
    output logic        [metricWidth-1:0] accMetricOut,
    output logic                          startNextStage
);

    logic signed [sampleWidth-1:0] tableReal [numPoints];
    logic signed [sampleWidth-1:0] tableImag [numPoints];
    logic signed [sampleWidth-1:0] blockReal;
    logic signed [sampleWidth-1:0] blockImag;
    pointIndex                     wrAddr;
    pointIndex                     metricAddr;
    logic                          running;

    // --------------------
    // point table
    // --------------------
    always_ff @(posedge clk) begin
        if (reset || startFrame) begin
            wrAddr <= '0;
        end else if (setupOutputValid) begin
            wrAddr <= wrAddr + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (setupOutputValid && !startFrame) begin
            tableReal[wrAddr] <= setupReal;
            tableImag[wrAddr] <= setupImag;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && startBlock) begin
            blockReal <= sampleReal;
            blockImag <= sampleImag;
        end
    end

    // metric address and end of stage
    always_ff @(posedge clk) begin
        if (reset || startFrame) begin
            metricAddr     <= '0;
            running        <= 1'b0;
            startNextStage <= 1'b0;
        end else if (startStage) begin
            metricAddr     <= '0;
            running        <= 1'b1;
            startNextStage <= 1'b0;
        end else begin
            startNextStage <= 1'b0;
            if (accMetricInEn) begin
                metricAddr <= metricAddr + 4'd1;
                if (running && metricAddr == pointIndex'(numPoints - 1)) begin
                    running        <= 1'b0;
                    startNextStage <= 1'b1;  // not delayed by acsOp
                end
            end
        end
    end

    acsOp #(
        .metricShift(metricShift)
    ) acs_i (
        .clk           (clk),
        .reset         (reset | startFrame),
        .yReal         (tableReal[metricAddr]),
        .yImag         (tableImag[metricAddr]),
        .sReal         (blockReal),
        .sImag         (blockImag),
        .accMetricInEn (accMetricInEn),
        .accMetricIn   (accMetricIn),
        .accMetricOutEn(metricOutEn),
        .accMetricOut  (accMetricOut)
    );

endmodule

`default_nettype wire

// File: source/acsDetector.sv
`timescale 1ns/1ps
`default_nettype none

module acsDetector import detectorPkg::*; #(
    parameter int metricShift = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clkEn,
    input  logic                          frameStart,
    input  logic signed [sampleWidth-1:0] chanReal,
    input  logic signed [sampleWidth-1:0] chanImag,
    input  logic                          blockValid,
    input  logic signed [sampleWidth-1:0] sampleReal,
    input  logic signed [sampleWidth-1:0] sampleImag,
    input  logic                          accMetricInEn,
    input  logic        [metricWidth-1:0] accMetricIn,
    output logic                          frameReady,
    output logic                          stageActive,
    output logic                          metricOutEn,
    output logic        [metricWidth-1:0] accMetricOut,
    output logic                          startNextStage
);

    logic                          startFrame;
    logic                          startBlock;
    logic                          startStage;
    logic                          stageSetupComplete;
    logic                          setupOutputValid;
    logic signed [sampleWidth-1:0] setupReal;
    logic signed [sampleWidth-1:0] setupImag;

    detectorControl control_i (
        .clk(clk), .reset(reset), .clkEn(clkEn),
        .frameStart(frameStart), .blockValid(blockValid),
        .stageSetupComplete(stageSetupComplete), .startNextStage(startNextStage),
        .startFrame(startFrame), .startBlock(startBlock), .startStage(startStage),
        .frameReady(frameReady), .stageActive(stageActive)
    );

    pointSetup setup_i (
        .clk(clk), .reset(reset), .startFrame(startFrame),
        .chanReal(chanReal), .chanImag(chanImag),
        .setupOutputValid(setupOutputValid), .stageSetupComplete(stageSetupComplete),
        .setupReal(setupReal), .setupImag(setupImag)
    );

    acsStage #(.metricShift(metricShift)) stage_i (
        .clk(clk), .reset(reset), .clkEn(clkEn),
        .startFrame(startFrame), .startBlock(startBlock), .startStage(startStage),
        .sampleReal(sampleReal), .sampleImag(sampleImag),
        .accMetricInEn(accMetricInEn), .accMetricIn(accMetricIn),
        .setupOutputValid(setupOutputValid), .setupReal(setupReal), .setupImag(setupImag),
        .metricOutEn(metricOutEn), .accMetricOut(accMetricOut),
        .startNextStage(startNextStage)
    );

endmodule

`default_nettype wire

// File: tb/acsDetectorTb.sv
`timescale 1ns/1ps
`default_nettype none

module acsDetectorTb import detectorPkg::*; ();

    localparam int metricShift = 16;
    localparam int clkPeriod   = 4;
    localparam int setupCycles = 45;
    localparam int stageCycles = 8 + numPoints * 4 + 20;
    localparam int runCycles   = 5 + 4 * (setupCycles + 4) + 6 * stageCycles + 200;

    logic clk = 1'b0;
    logic reset, clkEn, frameStart, blockValid, accMetricInEn, lastStrobe;
    logic signed [sampleWidth-1:0] chanReal, chanImag, sampleReal, sampleImag;
    logic [metricWidth-1:0] accMetricIn, accMetricOut, want;
    logic frameReady, stageActive, metricOutEn, startNextStage;
    logic enDly1 = 1'b0, enDly2 = 1'b0, strobeDly = 1'b0;

    int pointRe[numPoints], pointIm[numPoints];
    int blkRe, blkIm;
    logic [metricWidth-1:0] expected[$];
    int errors = 0, errAtStart = 0, testsRun = 0, testsFailed = 0;

    acsDetector #(.metricShift(metricShift)) dut_i (
        .clk(clk), .reset(reset), .clkEn(clkEn), .frameStart(frameStart),
        .chanReal(chanReal), .chanImag(chanImag), .blockValid(blockValid),
        .sampleReal(sampleReal), .sampleImag(sampleImag),
        .accMetricInEn(accMetricInEn), .accMetricIn(accMetricIn),
        .frameReady(frameReady), .stageActive(stageActive), .metricOutEn(metricOutEn),
        .accMetricOut(accMetricOut), .startNextStage(startNextStage)
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        enDly1    <= accMetricInEn;
        enDly2    <= enDly1;  // strobe seen two edges back
        strobeDly <= lastStrobe;
    end

    task automatic noteFailure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic reportMismatch(input string name, input longint exp, input longint got);
        $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
        errors++;
    endtask

    // --------------------
    // checks
    // --------------------
    assert property (@(posedge clk) reset |=> !frameReady && !stageActive && !metricOutEn
                     && !startNextStage && !dut_i.setup_i.setupOutputValid
                     && !dut_i.setup_i.stageSetupComplete)
        else noteFailure("control outputs not low after reset");
    assert property (@(posedge clk) disable iff (reset) metricOutEn == enDly2)
        else reportMismatch("metricOutEn", $sampled(enDly2), $sampled(metricOutEn));
    assert property (@(posedge clk) disable iff (reset) startNextStage == strobeDly)
        else reportMismatch("startNextStage", $sampled(strobeDly), $sampled(startNextStage));
    assert property (@(posedge clk) disable iff (reset) startNextStage |=> !stageActive)
        else noteFailure("stageActive still high after startNextStage");
    assert property (@(posedge clk) disable iff (reset)
                     blockValid && !frameReady && !stageActive |=> !stageActive)
        else noteFailure("a block started before the frame was ready");

    always @(posedge clk) begin
        if (!reset && metricOutEn) begin
            if (expected.size() == 0) begin
                noteFailure("metric output with no metric expected");
            end else begin
                want = expected.pop_front();
                assert (accMetricOut == want) else reportMismatch("accMetricOut", want, accMetricOut);
            end
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic int truncSample(input int v);
        logic signed [sampleWidth-1:0] t;
        t = v[sampleWidth-1:0];
        return int'(t);
    endfunction

    task automatic buildTable(input int hR, input int hI);
        int lI, lQ;
        for (int k = 0; k < numPoints; k++) begin
            lI = 2 * (k / 4) - 3;  // index bits 3:2
            lQ = 2 * (k % 4) - 3;
            pointRe[k] = truncSample((lI * hR - lQ * hI) >>> setupShift);
            pointIm[k] = truncSample((lI * hI + lQ * hR) >>> setupShift);
        end
    endtask

    function automatic logic [metricWidth-1:0] expectMetric(input int k, input int metricIn);
        longint dR, dI, total;
        dR = pointRe[k] - blkRe;
        dI = pointIm[k] - blkIm;
        total = ((dR * dR + dI * dI) >> metricShift) + metricIn;
        return (total > metricMax) ? metricMax : total[metricWidth-1:0];
    endfunction

    function automatic logic signed [sampleWidth-1:0] randomSample();
        return $urandom;
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic loadGain(input logic signed [sampleWidth-1:0] hR, hI);
        int cycles;
        @(posedge clk);
        frameStart <= 1'b1;
        chanReal   <= hR;
        chanImag   <= hI;
        buildTable(hR, hI);
        cycles = 0;
        do begin
            @(posedge clk);
            frameStart <= 1'b0;
            cycles++;
            @(negedge clk);
        end while (!frameReady && cycles < setupCycles);
        assert (cycles == 19) else reportMismatch("frameReady delay", 19, cycles);
    endtask

    task automatic ignoredFrame();
        logic wasReady;
        wasReady = frameReady;
        @(posedge clk);
        clkEn      <= 1'b0;
        frameStart <= 1'b1;
        chanReal   <= randomSample();
        @(posedge clk);
        clkEn      <= 1'b1;
        frameStart <= 1'b0;
        repeat (setupCycles) begin
            @(negedge clk);
            assert (frameReady == wasReady) else noteFailure("frameStart with clkEn low acted");
        end
    endtask

    task automatic pokeBlock();
        @(posedge clk);
        blockValid <= 1'b1;
        sampleReal <= randomSample();
        sampleImag <= randomSample();
        @(posedge clk);
        blockValid <= 1'b0;
    endtask

    task automatic startBlockWith(input logic signed [sampleWidth-1:0] sR, sI);
        int waited;
        @(posedge clk);
        blockValid <= 1'b1;
        sampleReal <= sR;
        sampleImag <= sI;
        blkRe = sR;
        blkIm = sI;
        @(posedge clk);
        blockValid <= 1'b0;
        waited = 0;
        while (!stageActive && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!stageActive)
            noteFailure("block was not accepted");
    endtask

    task automatic streamMetrics(input bit withGaps, input bit nearMax);
        int metric, gap, waited;
        for (int k = 0; k < numPoints; k++) begin
            gap = withGaps ? $urandom_range(3, 0) : 0;
            repeat (gap) begin
                @(posedge clk);
                accMetricInEn <= 1'b0;
                lastStrobe    <= 1'b0;
            end
            metric = nearMax ? int'(metricMax) - $urandom_range(7, 0) : $urandom_range(200000, 0);
            @(posedge clk);
            accMetricInEn <= 1'b1;
            accMetricIn   <= metric[metricWidth-1:0];
            lastStrobe    <= (k == numPoints - 1);
            expected.push_back(expectMetric(k, metric));
        end
        @(posedge clk);
        accMetricInEn <= 1'b0;
        lastStrobe    <= 1'b0;
        waited = 0;
        while ((stageActive || expected.size() != 0) && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (stageActive || expected.size() != 0)
            noteFailure("stage did not finish");
    endtask

    task automatic closeTest(input string name);
        testsRun++;
        if (errors != errAtStart)
            testsFailed++;
        $display("%s: %s", name, (errors != errAtStart) ? "FAIL" : "ok");
        errAtStart = errors;
    endtask

    initial begin
        void'($urandom(32'h7e11_7d8d));
        reset         <= 1'b1;
        clkEn         <= 1'b1;
        frameStart    <= 1'b0;
        blockValid    <= 1'b0;
        accMetricInEn <= 1'b0;
        lastStrobe    <= 1'b0;
        chanReal      <= '0;
        chanImag      <= '0;
        sampleReal    <= '0;
        sampleImag    <= '0;
        accMetricIn   <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        ignoredFrame();
        pokeBlock();  // no frame loaded yet
        loadGain(randomSample(), randomSample());
        ignoredFrame();
        closeTest("reset and setup timing");

        startBlockWith(randomSample(), randomSample());
        streamMetrics(1'b0, 1'b0);
        closeTest("metrics back to back");

        startBlockWith(randomSample(), randomSample());
        streamMetrics(1'b1, 1'b0);
        closeTest("metrics with gaps");

        startBlockWith(18'sh20000, 18'sh20000);  // far corner
        streamMetrics(1'b1, 1'b1);
        closeTest("saturation");

        startBlockWith(randomSample(), randomSample());
        pokeBlock();  // while stage is active
        streamMetrics(1'b1, 1'b0);
        closeTest("block gating");

        loadGain(randomSample(), randomSample());
        startBlockWith(randomSample(), randomSample());
        streamMetrics(1'b1, 1'b0);
        closeTest("re-setup");

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // watchdog
    initial begin
        #(runCycles * clkPeriod);
        $display("timeout: the run did not finish within %0d cycles", runCycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/detectorPkg.sv
source/detectorControl.sv
source/pointSetup.sv
source/acsOp.sv
source/acsStage.sv
source/acsDetector.sv
tb/acsDetectorTb.sv

// File: Bender.yml
package:
  name: acs_detector

sources:
  - files:
      - source/detectorPkg.sv
      - source/detectorControl.sv
      - source/pointSetup.sv
      - source/acsOp.sv
      - source/acsStage.sv
      - source/acsDetector.sv
  - target: test
    files:
      - tb/acsDetectorTb.sv
